// ==== Bender.yml ====
package:
  name: output_writer

sources:
  - files:
      - design/output_writer_pkg.sv
      - design/stream_row_packer.sv
      - design/row_buffer.sv
      - design/axi_row_writer.sv
      - design/output_writer_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/output_writer_tb.sv

// ==== design/axi_row_writer.sv ====
module axi_row_writer
	import output_writer_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int BURST_LEN = 8
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  logic                   row_ready,
	input  slot_t                  read_slot,
	input  ram_word_u              rd_data,
	input  dim_t                   no_of_input_layers,
	input  dim_t                   input_layer_row_size,
	input  logic [7:0]             burst_per_row,
	input  dim_t                   allocated_space_per_row,
	input  logic [ADDR_WIDTH-1:0]  axi_address,
	input  logic                   larger_block_en,
	input  logic                   awready,
	input  logic                   wready,
	output word_addr_t             rd_word,
	output logic                   row_sent,
	output logic [ADDR_WIDTH-1:0]  awaddr,
	output logic                   awvalid,
	output logic [WORD_WIDTH-1:0]  wdata,
	output logic                   wlast,
	output logic                   wvalid,
	output logic                   done
);

	localparam int BEAT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam int BURST_BYTES = BURST_LEN * WORD_BYTES;

	localparam logic [1:0] R_IDLE = 2'd0;
	localparam logic [1:0] R_BUSY = 2'd1;
	localparam logic [1:0] R_RELEASE = 2'd2;

	localparam logic [1:0] B_IDLE = 2'd0;
	localparam logic [1:0] B_SETUP = 2'd1;
	localparam logic [1:0] B_ADDR = 2'd2;
	localparam logic [1:0] B_DATA = 2'd3;

	logic [1:0] row_state;
	logic [1:0] burst_state;
	slot_t row_slot;
	dim_t layer_idx;
	dim_t row_idx;
	logic [ADDR_WIDTH-1:0] row_base;
	logic [ADDR_WIDTH-1:0] layer_off;
	logic [ADDR_WIDTH-1:0] burst_off;
	logic [7:0] burst_idx;
	logic [BEAT_W-1:0] beat_idx;
	word_addr_t word_idx;
	logic row_start;
	logic row_end;
	logic beat_fire;
	logic last_beat;
	logic burst_last;
	logic layer_last;
	logic row_last;

	assign beat_fire = wvalid && wready;
	assign last_beat = beat_idx == BEAT_W'(BURST_LEN - 1);
	assign burst_last = burst_idx == burst_per_row - 8'd1;
	assign layer_last = layer_idx == no_of_input_layers - 1'b1;
	assign row_last = row_idx == input_layer_row_size - 1'b1;

	assign row_start = row_state == R_IDLE && row_ready && !done;
	assign row_end = burst_state == B_DATA && beat_fire && last_beat && burst_last;

	// ----------------------------------------
	// row level
	// ----------------------------------------

	// waits in R_RELEASE until the buffer has moved past the sent slot
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			row_state <= R_IDLE;
			row_slot <= '0;
			row_sent <= 1'b0;
			done <= 1'b0;
			layer_idx <= '0;
			row_idx <= '0;
			row_base <= '0;
		end else begin
			row_sent <= 1'b0;
			case (row_state)
				R_IDLE: begin
					if (row_start) begin
						row_slot <= read_slot;
						row_state <= R_BUSY;
					end
				end
				R_BUSY: begin
					if (row_end) begin
						row_sent <= 1'b1;
						row_state <= R_RELEASE;
						if (layer_last) begin
							layer_idx <= '0;
							row_idx <= row_idx + 1'b1;
							row_base <= row_base + ADDR_WIDTH'(allocated_space_per_row);
							done <= row_last;
						end else begin
							layer_idx <= layer_idx + 1'b1;
						end
					end
				end
				R_RELEASE: begin
					if (read_slot != row_slot) begin
						row_state <= R_IDLE;
					end
				end
				default: row_state <= R_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// burst level
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			burst_state <= B_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			burst_idx <= '0;
			beat_idx <= '0;
			word_idx <= '0;
		end else begin
			case (burst_state)
				B_IDLE: begin
					if (row_start) begin
						burst_idx <= '0;
						word_idx <= '0;
						burst_state <= B_SETUP;
					end
				end
				B_SETUP: begin
					awvalid <= 1'b1;
					burst_state <= B_ADDR;
				end
				B_ADDR: begin
					if (awready) begin
						awvalid <= 1'b0;
						wvalid <= 1'b1;
						beat_idx <= '0;
						burst_state <= B_DATA;
					end
				end
				B_DATA: begin
					if (wready) begin
						word_idx <= word_idx + 1'b1;
						if (last_beat) begin
							wvalid <= 1'b0;
							if (burst_last) begin
								burst_state <= B_IDLE;
							end else begin
								burst_idx <= burst_idx + 1'b1;
								burst_state <= B_SETUP;
							end
						end else begin
							beat_idx <= beat_idx + 1'b1;
						end
					end
				end
				default: burst_state <= B_IDLE;
			endcase
		end
	end

	// address of the current burst, latched once per burst
	assign layer_off = larger_block_en ? (ADDR_WIDTH'(layer_idx) << 16)
		: (ADDR_WIDTH'(layer_idx) << 12);
	assign burst_off = ADDR_WIDTH'(burst_idx) * ADDR_WIDTH'(BURST_BYTES);

	always_ff @(posedge clk) begin
		if (burst_state == B_SETUP) begin
			awaddr <= axi_address + layer_off + row_base + burst_off;
		end
	end

	// look one word ahead on each accepted beat so wdata is ready next cycle
	assign rd_word = beat_fire ? word_idx + 1'b1 : word_idx;
	assign wdata = rd_data.word;
	assign wlast = wvalid && last_beat;

	a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n || start)
		awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

// ==== design/output_writer_pkg.sv ====
package output_writer_pkg;

	// ----------------------------------------
	// word and beat geometry
	// ----------------------------------------

	// one stream element per byte, eight per word
	localparam int WORD_BYTES = 8;
	localparam int WORD_WIDTH = 64;

	// lane index width inside a word
	localparam int LANE_W = $clog2(WORD_BYTES);

	// ----------------------------------------
	// row buffer geometry
	// ----------------------------------------

	// four row slots, each long enough for 64 beats
	localparam int SLOT_COUNT = 4;
	localparam int SLOT_WORDS = 64;

	// wide enough to count 0 to SLOT_COUNT
	localparam int OCC_W = $clog2(SLOT_COUNT + 1);

	// ----------------------------------------
	// scalar types
	// ----------------------------------------

	typedef logic [7:0] byte_t;

	// layer, row and column sizes and indices
	typedef logic [9:0] dim_t;

	typedef logic [1:0] slot_t;
	typedef logic [5:0] word_addr_t;

	// slot in the upper bits, word in the lower bits
	typedef logic [7:0] buf_addr_t;

	// ----------------------------------------
	// buffer word
	// ----------------------------------------

	// lane 0 is the lowest byte, so lanes fill little-endian
	typedef union packed {
		logic [WORD_WIDTH-1:0] word;
		byte_t [WORD_BYTES-1:0] lanes;
	} ram_word_u;

endpackage

// ==== design/output_writer_top.sv ====
module output_writer_top
	import output_writer_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int BURST_LEN = 8
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  byte_t                  fifo_data,
	input  dim_t                   fifo_dcount,
	input  dim_t                   no_of_input_layers,
	input  dim_t                   input_layer_row_size,
	input  dim_t                   input_layer_col_size,
	input  logic [7:0]             burst_per_row,
	input  dim_t                   allocated_space_per_row,
	input  logic [ADDR_WIDTH-1:0]  axi_address,
	input  logic                   larger_block_en,
	input  logic                   awready,
	input  logic                   wready,
	output logic                   fifo_rd_en,
	output logic [ADDR_WIDTH-1:0]  awaddr,
	output logic                   awvalid,
	output logic [WORD_WIDTH-1:0]  wdata,
	output logic                   wlast,
	output logic                   wvalid,
	output logic                   done
);

	// packer to buffer
	logic wr_en;
	buf_addr_t wr_addr;
	ram_word_u wr_data;
	logic row_written;
	logic space_free;

	// buffer to writer
	logic row_ready;
	slot_t read_slot;
	word_addr_t rd_word;
	ram_word_u rd_data;
	logic row_sent;

	stream_row_packer i_stream_row_packer (
		.clk                  (clk),
		.reset_n              (reset_n),
		.start                (start),
		.fifo_data            (fifo_data),
		.fifo_dcount          (fifo_dcount),
		.no_of_input_layers   (no_of_input_layers),
		.input_layer_row_size (input_layer_row_size),
		.input_layer_col_size (input_layer_col_size),
		.space_free           (space_free),
		.fifo_rd_en           (fifo_rd_en),
		.wr_en                (wr_en),
		.wr_addr              (wr_addr),
		.wr_data              (wr_data),
		.row_written          (row_written)
	);

	row_buffer i_row_buffer (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.row_written (row_written),
		.rd_word     (rd_word),
		.row_sent    (row_sent),
		.rd_data     (rd_data),
		.space_free  (space_free),
		.row_ready   (row_ready),
		.read_slot   (read_slot)
	);

	axi_row_writer #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.BURST_LEN  (BURST_LEN)
	) i_axi_row_writer (
		.clk                     (clk),
		.reset_n                 (reset_n),
		.start                   (start),
		.row_ready               (row_ready),
		.read_slot               (read_slot),
		.rd_data                 (rd_data),
		.no_of_input_layers      (no_of_input_layers),
		.input_layer_row_size    (input_layer_row_size),
		.burst_per_row           (burst_per_row),
		.allocated_space_per_row (allocated_space_per_row),
		.axi_address             (axi_address),
		.larger_block_en         (larger_block_en),
		.awready                 (awready),
		.wready                  (wready),
		.rd_word                 (rd_word),
		.row_sent                (row_sent),
		.awaddr                  (awaddr),
		.awvalid                 (awvalid),
		.wdata                   (wdata),
		.wlast                   (wlast),
		.wvalid                  (wvalid),
		.done                    (done)
	);

endmodule

// ==== design/row_buffer.sv ====
module row_buffer
	import output_writer_pkg::*;
(
	input  logic        clk,
	input  logic        reset_n,
	input  logic        start,
	input  logic        wr_en,
	input  buf_addr_t   wr_addr,
	input  ram_word_u   wr_data,
	input  logic        row_written,
	input  word_addr_t  rd_word,
	input  logic        row_sent,
	output ram_word_u   rd_data,
	output logic        space_free,
	output logic        row_ready,
	output slot_t       read_slot
);

	ram_word_u mem [SLOT_COUNT*SLOT_WORDS];
	logic [OCC_W-1:0] occupancy;
	buf_addr_t rd_addr;

	// ----------------------------------------
	// dual-port storage
	// ----------------------------------------

	assign rd_addr = {read_slot, rd_word};

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, one cycle of latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

	// ----------------------------------------
	// slot bookkeeping
	// ----------------------------------------

	// both strobes in one cycle leave the count unchanged
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			occupancy <= '0;
		end else begin
			case ({row_written, row_sent})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			read_slot <= '0;
		end else if (row_sent) begin
			read_slot <= read_slot + 1'b1;
		end
	end

	// one slot stays in reserve for the row the packer is still filling
	assign space_free = occupancy < OCC_W'(SLOT_COUNT - 1);
	assign row_ready = occupancy != '0;

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n || start)
		row_written |-> occupancy < OCC_W'(SLOT_COUNT));

	a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n || start)
		row_sent |-> occupancy != '0);

endmodule

// ==== design/stream_row_packer.sv ====
module stream_row_packer
	import output_writer_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	input  logic       start,
	input  byte_t      fifo_data,
	input  dim_t       fifo_dcount,
	input  dim_t       no_of_input_layers,
	input  dim_t       input_layer_row_size,
	input  dim_t       input_layer_col_size,
	input  logic       space_free,
	output logic       fifo_rd_en,
	output logic       wr_en,
	output buf_addr_t  wr_addr,
	output ram_word_u  wr_data,
	output logic       row_written
);

	logic running;
	dim_t col_idx;
	dim_t layer_idx;
	dim_t row_idx;
	logic col_last;
	logic layer_last;
	logic row_last;
	logic last_byte;
	logic rd_valid;
	logic rd_row_end;
	logic [LANE_W-1:0] lane;
	ram_word_u pack;
	ram_word_u pack_next;
	logic word_done;
	slot_t wr_slot;
	word_addr_t wr_word;

	// ----------------------------------------
	// read side: stream position
	// ----------------------------------------

	assign col_last = col_idx == input_layer_col_size - 1'b1;
	assign layer_last = layer_idx == no_of_input_layers - 1'b1;
	assign row_last = row_idx == input_layer_row_size - 1'b1;

	// rd_en for the very last byte of the whole transfer
	assign last_byte = fifo_rd_en && col_last && layer_last && row_last;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			running <= 1'b0;
		end else if (start) begin
			running <= 1'b1;
		end else if (last_byte) begin
			running <= 1'b0;
		end
	end

	// columns inside layers inside rows
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			col_idx <= '0;
			layer_idx <= '0;
			row_idx <= '0;
		end else if (fifo_rd_en) begin
			if (col_last) begin
				col_idx <= '0;
				if (layer_last) begin
					layer_idx <= '0;
					row_idx <= row_idx + 1'b1;
				end else begin
					layer_idx <= layer_idx + 1'b1;
				end
			end else begin
				col_idx <= col_idx + 1'b1;
			end
		end
	end

	// a count of 1 only allows a read when the previous cycle did not read
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			fifo_rd_en <= 1'b0;
		end else begin
			fifo_rd_en <= running && !last_byte && space_free &&
				(fifo_dcount >= 10'd2 || (fifo_dcount == 10'd1 && !fifo_rd_en));
		end
	end

	// fifo_data is valid the cycle after rd_en
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			rd_valid <= 1'b0;
			rd_row_end <= 1'b0;
		end else begin
			rd_valid <= fifo_rd_en;
			rd_row_end <= fifo_rd_en && col_last;
		end
	end

	// ----------------------------------------
	// byte packing
	// ----------------------------------------

	always_comb begin
		pack_next = pack;
		pack_next.lanes[lane] = fifo_data;
	end

	assign word_done = rd_valid && (lane == LANE_W'(WORD_BYTES - 1) || rd_row_end);

	// cleared after every write so a partial last word has zero upper lanes
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			lane <= '0;
			pack <= '0;
		end else if (word_done) begin
			lane <= '0;
			pack <= '0;
		end else if (rd_valid) begin
			lane <= lane + 1'b1;
			pack <= pack_next;
		end
	end

	// write port, one slot per row and layer
	always_ff @(posedge clk) begin
		if (!reset_n || start) begin
			wr_en <= 1'b0;
			row_written <= 1'b0;
			wr_slot <= '0;
			wr_word <= '0;
		end else begin
			wr_en <= word_done;
			row_written <= word_done && rd_row_end;
			if (word_done) begin
				if (rd_row_end) begin
					wr_word <= '0;
					wr_slot <= wr_slot + 1'b1;
				end else begin
					wr_word <= wr_word + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_done) begin
			wr_data <= pack_next;
			wr_addr <= {wr_slot, wr_word};
		end
	end

	a_no_read_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
		fifo_rd_en |-> fifo_dcount != '0);

endmodule

// ==== output_writer_top.f ====
+incdir+sim
design/output_writer_pkg.sv
design/stream_row_packer.sv
design/row_buffer.sv
design/axi_row_writer.sv
design/output_writer_top.sv
sim/output_writer_tb.sv

// ==== sim/output_writer_checks.svh ====
`ifndef OUTPUT_WRITER_CHECKS_SVH
`define OUTPUT_WRITER_CHECKS_SVH

	// ----------------------------------------
	// error counters and compare tasks
	// ----------------------------------------

	int addr_errors = 0;
	int data_errors = 0;
	int last_errors = 0;
	int other_errors = 0;

	task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] expected,
		input logic [ADDR_WIDTH-1:0] actual);
		if (actual !== expected) begin
			addr_errors++;
			$display("Fail %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input ram_word_u expected,
		input ram_word_u actual);
		if (actual !== expected) begin
			data_errors++;
			$display("Fail %s: expected %h, got %h", name, expected.word, actual.word);
		end
	endtask

	task automatic check_last(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			last_errors++;
			$display("Fail %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	function automatic int total_errors();
		return addr_errors + data_errors + last_errors + other_errors;
	endfunction

	// base + layer block + row stride + burst offset, eight bytes per beat
	function automatic logic [ADDR_WIDTH-1:0] expected_addr(
		input logic [ADDR_WIDTH-1:0] base, input int layer, input int row, input int burst,
		input int alloc, input logic big);
		int block_bytes;
		block_bytes = big ? 65536 : 4096;
		return base + ADDR_WIDTH'(layer * block_bytes) + ADDR_WIDTH'(row * alloc)
			+ ADDR_WIDTH'(burst * BURST_LEN * 8);
	endfunction

`endif

// ==== sim/output_writer_tb.sv ====
module output_writer_tb
	import output_writer_pkg::*;
#(
	parameter int ADDR_WIDTH = 32,
	parameter int BURST_LEN = 8
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int READY_HIGH = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_STALL = 2;
	localparam int FIFO_DEPTH = 512;
	localparam int RUN_LIMIT = 20000;

	logic clk;
	logic reset_n;
	logic start;
	byte_t fifo_data;
	dim_t fifo_dcount;
	dim_t no_of_input_layers;
	dim_t input_layer_row_size;
	dim_t input_layer_col_size;
	logic [7:0] burst_per_row;
	dim_t allocated_space_per_row;
	logic [ADDR_WIDTH-1:0] axi_address;
	logic larger_block_en;
	logic awready;
	logic wready;
	logic fifo_rd_en;
	logic [ADDR_WIDTH-1:0] awaddr;
	logic awvalid;
	logic [WORD_WIDTH-1:0] wdata;
	logic wlast;
	logic wvalid;
	logic done;

	int seed = 32'ha1d2;

	// stream bytes not yet in the FIFO, and the FIFO itself
	byte_t src_q[$];
	byte_t fifo_q[$];
	logic [ADDR_WIDTH-1:0] exp_addr_q[$];
	ram_word_u exp_word_q[$];

	logic check_en;
	logic slow_feed;
	int ready_mode;
	int stall_left;
	int aw_count;
	int beat_cnt;
	logic burst_open;
	logic buffer_filled;
	logic [31:0] rnd;
	logic [31:0] feed_rnd;
	int feed_n;

	`include "output_writer_checks.svh"

	output_writer_top #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.BURST_LEN  (BURST_LEN)
	) i_output_writer_top (
		.clk                     (clk),
		.reset_n                 (reset_n),
		.start                   (start),
		.fifo_data               (fifo_data),
		.fifo_dcount             (fifo_dcount),
		.no_of_input_layers      (no_of_input_layers),
		.input_layer_row_size    (input_layer_row_size),
		.input_layer_col_size    (input_layer_col_size),
		.burst_per_row           (burst_per_row),
		.allocated_space_per_row (allocated_space_per_row),
		.axi_address             (axi_address),
		.larger_block_en         (larger_block_en),
		.awready                 (awready),
		.wready                  (wready),
		.fifo_rd_en              (fifo_rd_en),
		.awaddr                  (awaddr),
		.awvalid                 (awvalid),
		.wdata                   (wdata),
		.wlast                   (wlast),
		.wvalid                  (wvalid),
		.done                    (done)
	);

	always #10 clk = ~clk;

	// ----------------------------------------
	// FIFO model
	// ----------------------------------------

	// data follows rd_en by one cycle, dcount is the queue size
	always @(posedge clk) begin
		if (fifo_rd_en) begin
			if (fifo_q.size() != 0) begin
				fifo_data <= fifo_q.pop_front();
			end else if (check_en) begin
				other_errors++;
				$display("FIFO was read while it was empty");
			end
		end
		// a start pulse flushes the FIFO in the cycle the DUT restarts
		if (start) begin
			fifo_q.delete();
		end
		feed_rnd = $random(seed);
		feed_n = slow_feed ? int'(feed_rnd[1:0] == 2'd0) : 2;
		while (feed_n > 0 && src_q.size() != 0 && fifo_q.size() < FIFO_DEPTH) begin
			fifo_q.push_back(src_q.pop_front());
			feed_n--;
		end
		fifo_dcount <= dim_t'(fifo_q.size());
	end

	// ----------------------------------------
	// AXI slave model
	// ----------------------------------------

	always @(posedge clk) begin
		rnd = $random(seed);
		if (ready_mode == READY_HIGH) begin
			awready <= 1'b1;
			wready <= 1'b1;
		end else if (ready_mode == READY_STALL && stall_left > 0) begin
			awready <= 1'b0;
			wready <= 1'b0;
			stall_left--;
		end else begin
			awready <= rnd[0];
			wready <= rnd[1];
		end
	end

	// compares every accepted address and beat in order
	always @(posedge clk) begin
		if (check_en) begin
			if (awvalid && awready) begin
				if (burst_open) begin
					other_errors++;
					$display("address accepted before the previous burst ended");
				end
				if (exp_addr_q.size() == 0) begin
					other_errors++;
					$display("address transfer with no burst left to send");
				end else begin
					check_addr("awaddr", exp_addr_q.pop_front(), awaddr);
				end
				burst_open = 1'b1;
				aw_count++;
			end
			if (wvalid && wready) begin
				if (!burst_open) begin
					other_errors++;
					$display("write beat outside of a burst");
				end
				if (exp_word_q.size() == 0) begin
					other_errors++;
					$display("write beat with no data left to send");
				end else begin
					check_word("wdata", exp_word_q.pop_front(), wdata);
				end
				check_last("wlast", beat_cnt == BURST_LEN - 1, wlast);
				if (beat_cnt == BURST_LEN - 1) begin
					beat_cnt = 0;
					burst_open = 1'b0;
				end else begin
					beat_cnt++;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (check_en && !i_output_writer_top.space_free) begin
			buffer_filled = 1'b1;
		end
	end

	// ----------------------------------------
	// run control
	// ----------------------------------------

	task automatic start_run(input dim_t layers, input dim_t rows, input dim_t cols,
		input logic [7:0] bursts, input dim_t alloc, input logic [ADDR_WIDTH-1:0] base,
		input logic big, input int mode, input logic slow);
		ram_word_u word;
		byte_t value;
		int words;
		int col;
		int r;
		int l;
		int w;
		int lane;
		int b;

		// restart and drop whatever an earlier run left behind
		@(posedge clk);
		start <= 1'b1;
		no_of_input_layers <= layers;
		input_layer_row_size <= rows;
		input_layer_col_size <= cols;
		burst_per_row <= bursts;
		allocated_space_per_row <= alloc;
		axi_address <= base;
		larger_block_en <= big;
		check_en = 1'b0;
		src_q.delete();
		exp_addr_q.delete();
		exp_word_q.delete();
		ready_mode = mode;
		slow_feed = slow;
		stall_left = 1500;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);

		// rows outermost, then layers, then columns
		words = bursts * BURST_LEN;
		for (r = 0; r < rows; r++) begin
			for (l = 0; l < layers; l++) begin
				for (w = 0; w < words; w++) begin
					word = '0;
					for (lane = 0; lane < 8; lane++) begin
						col = w * 8 + lane;
						if (col < cols) begin
							value = byte_t'($random(seed));
							src_q.push_back(value);
							word.lanes[lane] = value;
						end
					end
					exp_word_q.push_back(word);
				end
				for (b = 0; b < bursts; b++) begin
					exp_addr_q.push_back(expected_addr(base, l, r, b, alloc, big));
				end
			end
		end
		aw_count = 0;
		beat_cnt = 0;
		burst_open = 1'b0;
		buffer_filled = 1'b0;
		check_en = 1'b1;
	endtask

	task automatic finish_run(input string name);
		int cycles;

		cycles = 0;
		while (done !== 1'b1 && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			other_errors++;
			$display("%s: timed out waiting for done", name);
		end
		if (exp_addr_q.size() != 0 || exp_word_q.size() != 0) begin
			other_errors++;
			$display("%s: %0d addresses and %0d beats never arrived", name,
				exp_addr_q.size(), exp_word_q.size());
		end
		if (burst_open) begin
			other_errors++;
			$display("%s: last burst ended without its final beat", name);
		end
		if (src_q.size() != 0 || fifo_q.size() != 0) begin
			other_errors++;
			$display("%s: %0d bytes were never read from the FIFO", name,
				src_q.size() + fifo_q.size());
		end
	endtask

	task automatic wait_bursts(input int count);
		int cycles;

		cycles = 0;
		while (aw_count < count && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (aw_count < count) begin
			other_errors++;
			$display("timed out waiting for %0d bursts", count);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_single_layer();
		start_run(10'd1, 10'd2, dim_t'(8 * BURST_LEN), 8'd1, 10'h100, 32'h1000_0000,
			1'b0, READY_HIGH, 1'b0);
		finish_run("single layer");
	endtask

	task automatic test_layer_shift();
		start_run(10'd3, 10'd2, dim_t'(8 * (BURST_LEN - 1) + 4), 8'd1, 10'h100,
			32'h2000_0000, 1'b0, READY_HIGH, 1'b0);
		finish_run("layer shift 12");
		start_run(10'd3, 10'd2, dim_t'(8 * (BURST_LEN - 1) + 4), 8'd1, 10'h100,
			32'h2000_0000, 1'b1, READY_HIGH, 1'b0);
		finish_run("layer shift 16");
	endtask

	task automatic test_two_bursts();
		start_run(10'd2, 10'd2, dim_t'(8 * (2 * BURST_LEN - 1) + 3), 8'd2, 10'h200,
			32'h3000_0040, 1'b0, READY_HIGH, 1'b0);
		finish_run("two bursts");
	endtask

	task automatic test_random_stalls();
		start_run(10'd2, 10'd3, dim_t'(8 * (2 * BURST_LEN - 1) + 5), 8'd2, 10'h300,
			32'h4000_0000, 1'b1, READY_RANDOM, 1'b0);
		finish_run("random stalls");
	endtask

	task automatic test_slow_fifo();
		start_run(10'd2, 10'd4, dim_t'(8 * (BURST_LEN - 1) + 5), 8'd1, 10'h080,
			32'h5000_0000, 1'b0, READY_STALL, 1'b1);
		finish_run("slow fifo");
		if (!buffer_filled) begin
			other_errors++;
			$display("slow fifo: the row buffer never filled up");
		end
	endtask

	// abandon a run halfway, then check a fresh one from its first burst
	task automatic test_restart();
		start_run(10'd2, 10'd3, dim_t'(8 * 2 * BURST_LEN - 1), 8'd2, 10'h200,
			32'h6000_0000, 1'b0, READY_RANDOM, 1'b0);
		wait_bursts(3);
		start_run(10'd2, 10'd2, dim_t'(8 * (BURST_LEN - 1) + 1), 8'd1, 10'h100,
			32'h7000_0000, 1'b1, READY_RANDOM, 1'b0);
		finish_run("restart");
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		start = 1'b0;
		fifo_data = '0;
		fifo_dcount = '0;
		no_of_input_layers = 10'd1;
		input_layer_row_size = 10'd1;
		input_layer_col_size = 10'd1;
		burst_per_row = 8'd1;
		allocated_space_per_row = '0;
		axi_address = '0;
		larger_block_en = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		check_en = 1'b0;
		slow_feed = 1'b0;
		ready_mode = READY_HIGH;
		stall_left = 0;
		aw_count = 0;
		beat_cnt = 0;
		burst_open = 1'b0;
		buffer_filled = 1'b0;

		repeat (16) @(posedge clk);
		reset_n <= 1'b1;

		test_single_layer();
		test_layer_shift();
		test_two_bursts();
		test_random_stalls();
		test_slow_fifo();
		test_restart();

		$display("error counts: address %0d, data %0d, wlast %0d, other %0d",
			addr_errors, data_errors, last_errors, other_errors);
		if (total_errors() == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
